//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module kernelTopTb -f verilog.f -o simv
	./obj_dir/simv | tee sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- logic/controlSlave.sv
// Addresses, write data and strobes are ignored.
// Every read returns the last error count and every response is OKAY.
`default_nettype none
`timescale 1ns/10ps

module controlSlave
  import fuzzKernelPkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic [WordWidth-1:0] araddr,
  input  logic                 arvalid,
  output logic                 arready,
  output logic [WordWidth-1:0] rdata,
  output logic [1:0]           rresp,
  output logic                 rvalid,
  input  logic                 rready,
  input  logic [WordWidth-1:0] awaddr,
  input  logic                 awvalid,
  output logic                 awready,
  input  logic [WordWidth-1:0] wdata,
  input  logic [3:0]           wstrb,
  input  logic                 wvalid,
  output logic                 wready,
  output logic [1:0]           bresp,
  output logic                 bvalid,
  input  logic                 bready,
  input  logic [WordWidth-1:0] lastErrorCount
);

  localparam logic [1:0] RespOkay = 2'b00;

  logic writeAccept;

  // Read loopback: accept, then respond until rready.
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      arready <= 1'b0;
      rvalid <= 1'b0;
    end
    else if (rvalid)
      rvalid <= !rready;
    else if (arready)
    begin
      arready <= 1'b0;
      rvalid <= 1'b1;
    end
    else
      arready <= arvalid;
  end

  // Write loopback waits for address and data together.
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      writeAccept <= 1'b0;
      bvalid <= 1'b0;
    end
    else if (bvalid)
      bvalid <= !bready;
    else if (writeAccept)
    begin
      writeAccept <= 1'b0;
      bvalid <= 1'b1;
    end
    else
      writeAccept <= awvalid && wvalid;
  end

  assign awready = writeAccept;
  assign wready = writeAccept;

  assign rdata = lastErrorCount;
  assign rresp = RespOkay;
  assign bresp = RespOkay;

endmodule

`default_nettype wire

//--- logic/fuzzKernelPkg.sv
// Widths and the parameter register map are fixed by the host register file.
// Offsets must stay in the order that paramFetch assembles them.
`default_nettype none

package fuzzKernelPkg;

  // Register and parameter word width.
  localparam int WordWidth = 32;

  // Memory address width.
  localparam int AddrWidth = 64;

  // Width of the data count returned by the fuzz engine.
  localparam int CountWidth = 64;

  // Number of parameter words fetched per run.
  localparam int NumParams = 8;

  // Index into the parameter sequence.
  typedef logic [$clog2(NumParams)-1:0] paramIndexT;

  // Base address (low, high), block length, test count, then the two result
  // addresses (low, high each).
  localparam logic [WordWidth-1:0] paramOffsets [0:NumParams-1] = '{
    32'h40, 32'h44, 32'h48, 32'h4C, 32'h50, 32'h54, 32'h58, 32'h5C
  };

  // One result word, read either as the full data count or as a
  // zero-padded error count.
  typedef union packed {
    logic [CountWidth-1:0] dataCount;
    struct packed {
      logic [WordWidth-1:0] pad;
      logic [WordWidth-1:0] errorCount;
    } errorView;
  } resultWordT;

endpackage

`default_nettype wire

//--- logic/kernelBus.sv
// Stage-to-stage channels. The source holds valid and every field steady
// until a cycle with valid high and stop low.
`default_nettype none
`timescale 1ns/10ps

// Test configuration from the fetch stage to the run stage.
interface configBus
  import fuzzKernelPkg::*;
();

  logic [AddrWidth-1:0] baseAddr;
  logic [WordWidth-1:0] blockLength;
  logic [WordWidth-1:0] testCount;
  logic [AddrWidth-1:0] errorAddr;
  logic [AddrWidth-1:0] dataCountAddr;
  logic                 valid;
  logic                 stop;

  modport source (
    output baseAddr, blockLength, testCount, errorAddr, dataCountAddr, valid,
    input  stop
  );

  modport sink (
    input  baseAddr, blockLength, testCount, errorAddr, dataCountAddr, valid,
    output stop
  );

endinterface

// Engine status plus its destination addresses, from run to write-back.
interface resultBus
  import fuzzKernelPkg::*;
();

  logic [AddrWidth-1:0]  errorAddr;
  logic [AddrWidth-1:0]  dataCountAddr;
  logic [WordWidth-1:0]  errorCount;
  logic [CountWidth-1:0] dataCount;
  logic                  valid;
  logic                  stop;

  modport source (
    output errorAddr, dataCountAddr, errorCount, dataCount, valid,
    input  stop
  );

  modport sink (
    input  errorAddr, dataCountAddr, errorCount, dataCount, valid,
    output stop
  );

endinterface

`default_nettype wire

//--- logic/kernelTop.sv
// The fuzz engine and the memory write path sit outside, behind plain ports.
// A new go may be taken while an earlier run is still writing back.
`default_nettype none
`timescale 1ns/10ps

module kernelTop
  import fuzzKernelPkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  goReady,
  output logic                  goStop,
  output logic                  doneReady,
  input  logic                  doneStop,
  output logic                  paramAddrReady,
  output logic [WordWidth-1:0]  paramAddrData,
  input  logic                  paramAddrStop,
  input  logic                  paramDataReady,
  input  logic [WordWidth-1:0]  paramDataData,
  output logic                  paramDataStop,
  output logic                  fuzzConfigValid,
  output logic [AddrWidth-1:0]  fuzzBaseAddr,
  output logic [WordWidth-1:0]  fuzzBlockLength,
  output logic [WordWidth-1:0]  fuzzTestCount,
  input  logic                  fuzzConfigStop,
  input  logic                  statusValid,
  input  logic [WordWidth-1:0]  statusErrorCount,
  input  logic [CountWidth-1:0] statusDataCount,
  output logic                  statusStop,
  output logic                  memWriteValid,
  output logic [AddrWidth-1:0]  memWriteAddr,
  output resultWordT            memWriteData,
  input  logic                  memWriteStop,
  input  logic                  memWriteDoneValid,
  output logic                  memWriteDoneStop,
  input  logic [WordWidth-1:0]  araddr,
  input  logic                  arvalid,
  output logic                  arready,
  output logic [WordWidth-1:0]  rdata,
  output logic [1:0]            rresp,
  output logic                  rvalid,
  input  logic                  rready,
  input  logic [WordWidth-1:0]  awaddr,
  input  logic                  awvalid,
  output logic                  awready,
  input  logic [WordWidth-1:0]  wdata,
  input  logic [3:0]            wstrb,
  input  logic                  wvalid,
  output logic                  wready,
  output logic [1:0]            bresp,
  output logic                  bvalid,
  input  logic                  bready
);

  logic [WordWidth-1:0] lastErrorCount;

  configBus cfgLink ();
  resultBus resLink ();

  paramFetch fetch (
    .clk, .reset, .goReady, .goStop,
    .paramAddrReady, .paramAddrData, .paramAddrStop,
    .paramDataReady, .paramDataData, .paramDataStop,
    .cfg (cfgLink.source)
  );

  testRunner runner (
    .clk, .reset, .cfg (cfgLink.sink),
    .fuzzConfigValid, .fuzzBaseAddr, .fuzzBlockLength, .fuzzTestCount, .fuzzConfigStop,
    .statusValid, .statusErrorCount, .statusDataCount, .statusStop,
    .res (resLink.source)
  );

  resultWriter writer (
    .clk, .reset, .res (resLink.sink),
    .memWriteValid, .memWriteAddr, .memWriteData, .memWriteStop,
    .memWriteDoneValid, .memWriteDoneStop,
    .doneReady, .doneStop, .lastErrorCount
  );

  // Host control registers.
  controlSlave control (
    .clk, .reset,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .lastErrorCount
  );

endmodule

`default_nettype wire

//--- logic/paramFetch.sv
// Parameter data words must come back in the order their addresses were issued.
// A new go is refused until the previous configuration has been handed on.
`default_nettype none
`timescale 1ns/10ps

module paramFetch
  import fuzzKernelPkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 goReady,
  output logic                 goStop,
  output logic                 paramAddrReady,
  output logic [WordWidth-1:0] paramAddrData,
  input  logic                 paramAddrStop,
  input  logic                 paramDataReady,
  input  logic [WordWidth-1:0] paramDataData,
  output logic                 paramDataStop,
  configBus.source             cfg
);

  localparam logic [1:0] StateReset = 2'd0;
  localparam logic [1:0] StateIdle  = 2'd1;
  localparam logic [1:0] StateFetch = 2'd2;

  localparam paramIndexT LastIndex = paramIndexT'(NumParams - 1);

  logic [1:0] state;
  logic       addrActive;
  paramIndexT addrIdx;
  paramIndexT dataIdx;
  logic       goTaken;
  logic       addrTaken;
  logic       dataTaken;
  logic [3:0] issuedCount;

  // Go is only taken while idle with an empty configuration register.
  assign goStop = (state != StateIdle) || cfg.valid;
  assign goTaken = goReady && !goStop;

  assign paramAddrReady = addrActive;
  assign paramAddrData = paramOffsets[addrIdx];
  assign addrTaken = paramAddrReady && !paramAddrStop;

  assign paramDataStop = (state != StateFetch);
  assign dataTaken = paramDataReady && !paramDataStop;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state <= StateReset;
      addrActive <= 1'b0;
      addrIdx <= '0;
      dataIdx <= '0;
      cfg.valid <= 1'b0;
    end
    else
    begin
      case (state)
        StateIdle:
          if (goTaken)
            state <= StateFetch;
        StateFetch:
          if (dataTaken && (dataIdx == LastIndex))
            state <= StateIdle;
        default:
          state <= StateIdle;
      endcase

      // Address counter walks the offset table.
      if (goTaken)
      begin
        addrActive <= 1'b1;
        addrIdx <= '0;
      end
      else if (addrTaken)
      begin
        addrIdx <= addrIdx + 1'b1;
        if (addrIdx == LastIndex)
          addrActive <= 1'b0;
      end

      // Data counter wraps back to zero after the last word.
      if (goTaken)
        dataIdx <= '0;
      else if (dataTaken)
        dataIdx <= dataIdx + 1'b1;

      if (dataTaken && (dataIdx == LastIndex))
        cfg.valid <= 1'b1;
      else if (cfg.valid && !cfg.stop)
        cfg.valid <= 1'b0;
    end
  end

  // Steer each returned word into its field.
  always_ff @(posedge clk)
  begin
    if (dataTaken)
    begin
      case (dataIdx)
        3'd0: cfg.baseAddr[WordWidth-1:0] <= paramDataData;
        3'd1: cfg.baseAddr[AddrWidth-1:WordWidth] <= paramDataData;
        3'd2: cfg.blockLength <= paramDataData;
        3'd3: cfg.testCount <= paramDataData;
        3'd4: cfg.errorAddr[WordWidth-1:0] <= paramDataData;
        3'd5: cfg.errorAddr[AddrWidth-1:WordWidth] <= paramDataData;
        3'd6: cfg.dataCountAddr[WordWidth-1:0] <= paramDataData;
        default: cfg.dataCountAddr[AddrWidth-1:WordWidth] <= paramDataData;
      endcase
    end
  end

  // Addresses handed out so far in this fetch.
  assign issuedCount = addrActive ? {1'b0, addrIdx} : 4'(NumParams);

  dataFollowsAddr: assert property (@(posedge clk) disable iff (reset)
    dataTaken |-> (issuedCount > {1'b0, dataIdx}))
    else $error("parameter data word taken with no address outstanding");

endmodule

`default_nettype wire

//--- logic/resultWriter.sv
// Each memory write must be answered by exactly one done before the next is issued.
// lastErrorCount changes as soon as a new result is taken.
`default_nettype none
`timescale 1ns/10ps

module resultWriter
  import fuzzKernelPkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  resultBus.sink               res,
  output logic                 memWriteValid,
  output logic [AddrWidth-1:0] memWriteAddr,
  output resultWordT           memWriteData,
  input  logic                 memWriteStop,
  input  logic                 memWriteDoneValid,
  output logic                 memWriteDoneStop,
  output logic                 doneReady,
  input  logic                 doneStop,
  output logic [WordWidth-1:0] lastErrorCount
);

  localparam logic [1:0] WriteIdle   = 2'd0;
  localparam logic [1:0] WriteError  = 2'd1;
  localparam logic [1:0] WriteCount  = 2'd2;
  localparam logic [1:0] WriteReport = 2'd3;

  logic [1:0]            state;
  logic                  writeIssued;
  logic [AddrWidth-1:0]  errorAddr;
  logic [AddrWidth-1:0]  dataCountAddr;
  logic [WordWidth-1:0]  heldErrorCount;
  logic [CountWidth-1:0] heldDataCount;
  logic                  resTaken;
  logic                  writeTaken;
  logic                  writeDone;

  assign res.stop = (state != WriteIdle);
  assign resTaken = res.valid && !res.stop;

  // A write is offered once, then its done is awaited.
  assign memWriteValid = ((state == WriteError) || (state == WriteCount)) && !writeIssued;
  assign writeTaken = memWriteValid && !memWriteStop;
  assign memWriteDoneStop = !writeIssued;
  assign writeDone = memWriteDoneValid && !memWriteDoneStop;

  assign doneReady = (state == WriteReport);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state <= WriteIdle;
      writeIssued <= 1'b0;
      lastErrorCount <= '0;
    end
    else
    begin
      case (state)
        WriteIdle:
          if (resTaken)
            state <= WriteError;
        WriteError:
          if (writeDone)
            state <= WriteCount;
        WriteCount:
          if (writeDone)
            state <= WriteReport;
        default:
          if (!doneStop)
            state <= WriteIdle;
      endcase

      if (writeTaken)
        writeIssued <= 1'b1;
      else if (writeDone)
        writeIssued <= 1'b0;

      if (resTaken)
        lastErrorCount <= res.errorCount;
    end
  end

  always_ff @(posedge clk)
  begin
    if (resTaken)
    begin
      errorAddr <= res.errorAddr;
      dataCountAddr <= res.dataCountAddr;
      heldErrorCount <= res.errorCount;
      heldDataCount <= res.dataCount;
    end
  end

  // Error view first, then the full data count.
  always_comb
  begin
    if (state == WriteCount)
    begin
      memWriteAddr = dataCountAddr;
      memWriteData.dataCount = heldDataCount;
    end
    else
    begin
      memWriteAddr = errorAddr;
      memWriteData.errorView.pad = '0;
      memWriteData.errorView.errorCount = heldErrorCount;
    end
  end

  // The memory may only answer a write that is outstanding.
  doneFollowsWrite: assert property (@(posedge clk) disable iff (reset)
    memWriteDoneValid |-> writeIssued)
    else $error("memory write done arrived with no write outstanding");

endmodule

`default_nettype wire

//--- logic/testRunner.sv
// One fuzz run is in flight at a time. A finished status waits in the
// result register, so a new configuration can launch before write-back ends.
`default_nettype none
`timescale 1ns/10ps

module testRunner
  import fuzzKernelPkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  configBus.sink                cfg,
  output logic                  fuzzConfigValid,
  output logic [AddrWidth-1:0]  fuzzBaseAddr,
  output logic [WordWidth-1:0]  fuzzBlockLength,
  output logic [WordWidth-1:0]  fuzzTestCount,
  input  logic                  fuzzConfigStop,
  input  logic                  statusValid,
  input  logic [WordWidth-1:0]  statusErrorCount,
  input  logic [CountWidth-1:0] statusDataCount,
  output logic                  statusStop,
  resultBus.source              res
);

  localparam logic [1:0] RunIdle   = 2'd0;
  localparam logic [1:0] RunLaunch = 2'd1;
  localparam logic [1:0] RunWait   = 2'd2;

  logic [1:0]           state;
  logic [AddrWidth-1:0] errorAddr;
  logic [AddrWidth-1:0] dataCountAddr;
  logic                 cfgTaken;
  logic                 launched;
  logic                 statusTaken;

  assign cfg.stop = (state != RunIdle);
  assign cfgTaken = cfg.valid && !cfg.stop;

  assign fuzzConfigValid = (state == RunLaunch);
  assign launched = fuzzConfigValid && !fuzzConfigStop;

  // Status waits while the previous result is still unread.
  assign statusStop = (state != RunWait) || res.valid;
  assign statusTaken = statusValid && !statusStop;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state <= RunIdle;
      res.valid <= 1'b0;
    end
    else
    begin
      case (state)
        RunIdle:
          if (cfgTaken)
            state <= RunLaunch;
        RunLaunch:
          if (launched)
            state <= RunWait;
        default:
          if (statusTaken)
            state <= RunIdle;
      endcase

      if (statusTaken)
        res.valid <= 1'b1;
      else if (res.valid && !res.stop)
        res.valid <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (cfgTaken)
    begin
      fuzzBaseAddr <= cfg.baseAddr;
      fuzzBlockLength <= cfg.blockLength;
      fuzzTestCount <= cfg.testCount;
      errorAddr <= cfg.errorAddr;
      dataCountAddr <= cfg.dataCountAddr;
    end
    // result addresses travel alongside the counts
    if (statusTaken)
    begin
      res.errorAddr <= errorAddr;
      res.dataCountAddr <= dataCountAddr;
      res.errorCount <= statusErrorCount;
      res.dataCount <= statusDataCount;
    end
  end

  configHeld: assert property (@(posedge clk) disable iff (reset)
    (fuzzConfigValid && fuzzConfigStop) |=>
      (fuzzConfigValid && $stable(fuzzBaseAddr) && $stable(fuzzTestCount)))
    else $error("fuzz configuration dropped before the engine took it");

endmodule

`default_nettype wire

//--- tb/kernelTopTb.sv
// Each table row runs once without stalls and once at its stall rate.
// Runs do not overlap. Host, engine and memory models answer with random stalls.
`default_nettype none
`timescale 1ns/10ps

module kernelTopTb
  import fuzzKernelPkg::*;
();

  localparam int NumRows = 4;
  localparam int NumRuns = 2 * NumRows;
  localparam int TimeoutCycles = NumRuns * 2000;

  // Parameter words per row, in fetch order.
  localparam logic [WordWidth-1:0] RowParams [0:NumRows-1][0:NumParams-1] = '{
    '{32'h0000_1000, 32'h0000_0001, 32'h0000_0400, 32'h0000_0010,
      32'h0000_8000, 32'h0000_0002, 32'h0000_8008, 32'h0000_0002},
    '{32'hdead_0000, 32'h0000_00ab, 32'h0000_1000, 32'h0000_0100,
      32'h1234_5670, 32'h0000_0000, 32'h1234_5678, 32'h0000_0000},
    '{32'h8000_0000, 32'hffff_ffff, 32'h0000_0040, 32'h0000_0001,
      32'hcafe_0000, 32'h0000_0010, 32'hcafe_0100, 32'h0000_0010},
    '{32'h0123_4567, 32'h89ab_cdef, 32'hffff_ffff, 32'h7fff_ffff,
      32'h0000_0f00, 32'h0000_0003, 32'h0000_0f80, 32'h0000_0003}
  };
  localparam logic [WordWidth-1:0] RowErrors [0:NumRows-1] = '{
    32'h0, 32'h3, 32'hffff_ffff, 32'h11
  };
  localparam logic [CountWidth-1:0] RowData [0:NumRows-1] = '{
    64'h400, 64'h1_0000_0000, 64'hffff_ffff_ffff_fffe, 64'h1234_5678_9abc_def0
  };
  // Stall rate in percent.
  localparam int unsigned RowStall [0:NumRows-1] = '{10, 25, 50, 75};

  logic                  clk;
  logic                  reset;
  logic                  goReady;
  logic                  goStop;
  logic                  doneReady;
  logic                  doneStop = 1'b1;
  logic                  paramAddrReady;
  logic [WordWidth-1:0]  paramAddrData;
  logic                  paramAddrStop = 1'b1;
  logic                  paramDataReady = 1'b0;
  logic [WordWidth-1:0]  paramDataData = '0;
  logic                  paramDataStop;
  logic                  fuzzConfigValid;
  logic [AddrWidth-1:0]  fuzzBaseAddr;
  logic [WordWidth-1:0]  fuzzBlockLength;
  logic [WordWidth-1:0]  fuzzTestCount;
  logic                  fuzzConfigStop = 1'b1;
  logic                  statusValid = 1'b0;
  logic [WordWidth-1:0]  statusErrorCount = '0;
  logic [CountWidth-1:0] statusDataCount = '0;
  logic                  statusStop;
  logic                  memWriteValid;
  logic [AddrWidth-1:0]  memWriteAddr;
  resultWordT            memWriteData;
  logic                  memWriteStop = 1'b1;
  logic                  memWriteDoneValid = 1'b0;
  logic                  memWriteDoneStop;
  logic [WordWidth-1:0]  araddr;
  logic                  arvalid;
  logic                  arready;
  logic [WordWidth-1:0]  rdata;
  logic [1:0]            rresp;
  logic                  rvalid;
  logic                  rready;
  logic [WordWidth-1:0]  awaddr;
  logic                  awvalid;
  logic                  awready;
  logic [WordWidth-1:0]  wdata;
  logic [3:0]            wstrb;
  logic                  wvalid;
  logic                  wready;
  logic [1:0]            bresp;
  logic                  bvalid;
  logic                  bready;

  // Model state, written only by the model processes.
  logic [WordWidth-1:0]  addrSeen [$];
  paramIndexT            dataPending [$];
  logic [AddrWidth-1:0]  engBase [$];
  logic [WordWidth-1:0]  engLength [$];
  logic [WordWidth-1:0]  engCount [$];
  logic [AddrWidth-1:0]  wrAddr [$];
  logic [CountWidth-1:0] wrData [$];
  bit                    statusOwed = 1'b0;
  bit                    doneOwed = 1'b0;
  int                    writesDone = 0;
  int                    writesAtDone = 0;
  int                    doneCount = 0;

  int unsigned           stallRate = 0;
  logic [1:0]            curRow = '0;
  int                    errorCount = 0;
  int                    runsPassed = 0;
  int                    runsFailed = 0;
  logic [CountWidth-1:0] refWrites [0:NumRows-1][0:1];

  kernelTop uut (.*);

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic stallNow();
    return ($urandom % 100) < stallRate;
  endfunction

  function automatic paramIndexT offsetIndex(input logic [WordWidth-1:0] addr);
    paramIndexT idx;
    idx = '0;
    for (int k = 0; k < NumParams; k++)
      if (paramOffsets[k] == addr)
        idx = paramIndexT'(k);
    return idx;
  endfunction

  // Host register file. Data words come back in address order.
  always @(posedge clk)
  begin
    if (reset)
    begin
      paramAddrStop <= 1'b1;
      paramDataReady <= 1'b0;
    end
    else
    begin
      if (paramAddrReady && !paramAddrStop)
      begin
        addrSeen.push_back(paramAddrData);
        dataPending.push_back(offsetIndex(paramAddrData));
      end
      paramAddrStop <= stallNow();
      if (paramDataReady && !paramDataStop)
        dataPending.delete(0);
      if (!(paramDataReady && paramDataStop))
      begin
        if ((dataPending.size() > 0) && !stallNow())
        begin
          paramDataReady <= 1'b1;
          paramDataData <= RowParams[curRow][dataPending[0]];
        end
        else
          paramDataReady <= 1'b0;
      end
    end
  end

  // Fuzz engine.
  always @(posedge clk)
  begin
    if (reset)
    begin
      fuzzConfigStop <= 1'b1;
      statusValid <= 1'b0;
      statusOwed = 1'b0;
    end
    else
    begin
      if (fuzzConfigValid && !fuzzConfigStop)
      begin
        engBase.push_back(fuzzBaseAddr);
        engLength.push_back(fuzzBlockLength);
        engCount.push_back(fuzzTestCount);
        statusOwed = 1'b1;
      end
      fuzzConfigStop <= stallNow();
      if (statusValid && !statusStop)
      begin
        statusValid <= 1'b0;
        statusOwed = 1'b0;
      end
      else if (statusOwed && !statusValid && !stallNow())
      begin
        statusValid <= 1'b1;
        statusErrorCount <= RowErrors[curRow];
        statusDataCount <= RowData[curRow];
      end
    end
  end

  // Memory write port and the host's done channel.
  always @(posedge clk)
  begin
    if (reset)
    begin
      memWriteStop <= 1'b1;
      memWriteDoneValid <= 1'b0;
      doneStop <= 1'b1;
      doneOwed = 1'b0;
    end
    else
    begin
      if (memWriteValid && !memWriteStop)
      begin
        wrAddr.push_back(memWriteAddr);
        wrData.push_back(memWriteData);
        doneOwed = 1'b1;
      end
      memWriteStop <= stallNow();
      if (memWriteDoneValid && !memWriteDoneStop)
      begin
        memWriteDoneValid <= 1'b0;
        doneOwed = 1'b0;
        writesDone++;
      end
      else if (doneOwed && !memWriteDoneValid && !stallNow())
        memWriteDoneValid <= 1'b1;
      if (doneReady && !doneStop)
      begin
        doneCount++;
        writesAtDone = writesDone;
      end
      doneStop <= stallNow();
    end
  end

  task automatic checkValue(input string name, input logic [63:0] got,
                            input logic [63:0] expected);
    assert (got === expected)
    else
    begin
      $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, expected);
      errorCount++;
    end
  endtask

  task automatic controlRead(output logic [WordWidth-1:0] data, output logic [1:0] resp);
    @(posedge clk);
    araddr <= 32'h10;
    arvalid <= 1'b1;
    rready <= 1'b1;
    do @(posedge clk); while (!arready);
    arvalid <= 1'b0;
    do @(posedge clk); while (!rvalid);
    data = rdata;
    resp = rresp;
    rready <= 1'b0;
  endtask

  task automatic controlWrite(output logic [1:0] resp);
    @(posedge clk);
    awaddr <= 32'h14;
    wdata <= 32'h5a5a_0001;
    wstrb <= 4'hf;
    awvalid <= 1'b1;
    wvalid <= 1'b1;
    bready <= 1'b1;
    do @(posedge clk); while (!awready);
    // Address and data are accepted in the same cycle.
    checkValue("wready", 64'(wready), 64'd1);
    awvalid <= 1'b0;
    wvalid <= 1'b0;
    do @(posedge clk); while (!bvalid);
    resp = bresp;
    bready <= 1'b0;
  endtask

  task automatic runTest(input int passIdx, input int rowIdx);
    int addrMark;
    int engMark;
    int wrMark;
    int doneMark;
    int writesMark;
    int errorsBefore;
    logic [WordWidth-1:0] readData;
    logic [1:0] readResp;
    logic [1:0] writeResp;
    errorsBefore = errorCount;
    addrMark = addrSeen.size();
    engMark = engBase.size();
    wrMark = wrAddr.size();
    doneMark = doneCount;
    writesMark = writesDone;
    curRow <= 2'(rowIdx);
    stallRate <= (passIdx == 0) ? 0 : RowStall[rowIdx];
    @(posedge clk);
    goReady <= 1'b1;
    do @(posedge clk); while (goStop);
    goReady <= 1'b0;
    wait (doneCount == doneMark + 1);
    repeat (4) @(posedge clk);
    controlRead(readData, readResp);
    controlWrite(writeResp);

    checkValue("address count", 64'(addrSeen.size() - addrMark), 64'(NumParams));
    if (addrSeen.size() == addrMark + NumParams)
      for (int i = 0; i < NumParams; i++)
        checkValue("paramAddrData", 64'(addrSeen[addrMark + i]), 64'(paramOffsets[i]));
    checkValue("engine launch count", 64'(engBase.size() - engMark), 64'd1);
    if (engBase.size() == engMark + 1)
    begin
      checkValue("fuzzBaseAddr", engBase[engMark],
                 {RowParams[rowIdx][1], RowParams[rowIdx][0]});
      checkValue("fuzzBlockLength", 64'(engLength[engMark]), 64'(RowParams[rowIdx][2]));
      checkValue("fuzzTestCount", 64'(engCount[engMark]), 64'(RowParams[rowIdx][3]));
    end
    checkValue("memory write count", 64'(wrAddr.size() - wrMark), 64'd2);
    if (wrAddr.size() == wrMark + 2)
    begin
      checkValue("memWriteAddr", wrAddr[wrMark], {RowParams[rowIdx][5], RowParams[rowIdx][4]});
      checkValue("memWriteData", wrData[wrMark], {32'h0, RowErrors[rowIdx]});
      checkValue("memWriteAddr", wrAddr[wrMark + 1],
                 {RowParams[rowIdx][7], RowParams[rowIdx][6]});
      checkValue("memWriteData", wrData[wrMark + 1], RowData[rowIdx]);
      // The stalled run must reproduce the no-stall results.
      if (passIdx == 0)
      begin
        refWrites[rowIdx][0] = wrData[wrMark];
        refWrites[rowIdx][1] = wrData[wrMark + 1];
      end
      else
      begin
        checkValue("memWriteData vs no-stall run", wrData[wrMark], refWrites[rowIdx][0]);
        checkValue("memWriteData vs no-stall run", wrData[wrMark + 1], refWrites[rowIdx][1]);
      end
    end
    checkValue("doneReady count", 64'(doneCount - doneMark), 64'd1);
    checkValue("writes done before doneReady", 64'(writesAtDone - writesMark), 64'd2);
    checkValue("rdata", 64'(readData), 64'(RowErrors[rowIdx]));
    checkValue("rresp", 64'(readResp), 64'd0);
    checkValue("bresp", 64'(writeResp), 64'd0);

    if (errorCount == errorsBefore)
      runsPassed++;
    else
      runsFailed++;
    $display("Run row %0d, stall %0d%%: %s", rowIdx, (passIdx == 0) ? 0 : RowStall[rowIdx],
             (errorCount == errorsBefore) ? "PASS" : "FAIL");
  endtask

  initial
  begin
    void'($urandom(32'h2175_c9cc));
    reset = 1'b1;
    goReady = 1'b0;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    wvalid = 1'b0;
    bready = 1'b0;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    for (int passIdx = 0; passIdx < 2; passIdx++)
      for (int rowIdx = 0; rowIdx < NumRows; rowIdx++)
        runTest(passIdx, rowIdx);
    $display("Runs: %0d passed, %0d failed, %0d failed checks",
             runsPassed, runsFailed, errorCount);
    if (errorCount == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

  // Watchdog.
  initial
  begin
    repeat (TimeoutCycles) @(posedge clk);
    $display("Timeout: the runs did not finish within %0d cycles", TimeoutCycles);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
logic/fuzzKernelPkg.sv
logic/kernelBus.sv
logic/paramFetch.sv
logic/testRunner.sv
logic/resultWriter.sv
logic/controlSlave.sv
logic/kernelTop.sv
tb/kernelTopTb.sv
